/* design/branch_unit.sv */
`timescale 1ns/100ps
`include "id_consts.svh"

module branch_unit (
	input  isa_pkg::instr_u    inst_i,
	input  logic [`REG_W-1:0]  pc_i,
	input  logic [`REG_W-1:0]  op1_i,
	input  logic [`REG_W-1:0]  op2_i,
	input  logic               stall_i,
	output pipe_pkg::branch_t  branch_o
);

	logic [`REG_W-1:0] pc_plus4;
	logic [`REG_W-1:0] br_offset;
	logic [`REG_W-1:0] j_target;
	logic [`REG_W-1:0] b_target;
	logic              taken_raw;

	assign pc_plus4  = pc_i + `REG_W'd4;
	assign br_offset = {{(`REG_W-`IMM_W-2){inst_i.i.imm[`IMM_W-1]}}, inst_i.i.imm, 2'b00};
	assign b_target  = pc_plus4 + br_offset;
	// region of the delay slot, index in words
	assign j_target  = {pc_plus4[`REG_W-1 -: 4], inst_i.j.index, 2'b00};

	always_comb begin
		taken_raw = 1'b0;
		branch_o.target = b_target;
		case (inst_i.j.opcode)
			isa_pkg::OP_J, isa_pkg::OP_JAL: begin
				taken_raw = 1'b1;
				branch_o.target = j_target;
			end
			isa_pkg::OP_BEQ: begin
				taken_raw = (op1_i == op2_i);
			end
			isa_pkg::OP_BNE: begin
				taken_raw = (op1_i != op2_i);
			end
			default: begin
				taken_raw = 1'b0;
			end
		endcase
	end

	// operands are not valid during a load-use stall
	assign branch_o.taken = taken_raw && !stall_i;

endmodule

/* design/id_consts.svh */
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// datapath and pc width
`define REG_W      32
`define REG_ADDR_W 5

// instruction field widths
`define OPCODE_W   6
`define FUNCT_W    6
`define IMM_W      16
`define JIDX_W     26

// JAL writes its return address here
`define LINK_REG   5'd31

`endif

/* design/id_ex_reg.sv */
`timescale 1ns/100ps
`include "id_consts.svh"

module id_ex_reg (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             stall_i,
	input  pipe_pkg::id_ex_t bundle_i,
	output pipe_pkg::id_ex_t id_ex_o
);

	logic insert_bubble;

	assign insert_bubble = rst_i || stall_i;

	// control fields
	always_ff @(posedge clk) begin
		if (insert_bubble) begin
			id_ex_o.aluop <= pipe_pkg::ALU_NOP;
			id_ex_o.wreg  <= 1'b0;
			id_ex_o.wd    <= '0;
		end else begin
			id_ex_o.aluop <= bundle_i.aluop;
			id_ex_o.wreg  <= bundle_i.wreg;
			id_ex_o.wd    <= bundle_i.wd;
		end
	end

	// payload, zeroed in a bubble so ex sees clean operands
	always_ff @(posedge clk) begin
		if (insert_bubble) begin
			id_ex_o.op1       <= '0;
			id_ex_o.op2       <= '0;
			id_ex_o.link_addr <= '0;
		end else begin
			id_ex_o.op1       <= bundle_i.op1;
			id_ex_o.op2       <= bundle_i.op2;
			id_ex_o.link_addr <= bundle_i.link_addr;
		end
	end

endmodule

/* design/id_stage.sv */
`timescale 1ns/100ps
`include "id_consts.svh"

module id_stage (
	input  logic               clk,
	input  logic               rst_i,
	input  logic [`REG_W-1:0]  pc_i,
	input  isa_pkg::instr_u    inst_i,
	input  pipe_pkg::fwd_src_t ex_fwd_i,
	input  pipe_pkg::fwd_src_t mem_fwd_i,
	input  logic [`REG_W-1:0]  rf_data1_i,
	input  logic [`REG_W-1:0]  rf_data2_i,
	output pipe_pkg::rf_read_t rf_rd_o,
	output pipe_pkg::branch_t  branch_o,
	output logic               stall_o,
	output pipe_pkg::id_ex_t   id_ex_o
);

	pipe_pkg::alu_op_e      aluop;
	logic [`REG_ADDR_W-1:0] wd;
	logic                   wreg;
	logic [`REG_W-1:0]      imm;
	logic                   use_imm;
	logic [`REG_W-1:0]      link_addr;
	logic [`REG_W-1:0]      fwd1_data;
	logic [`REG_W-1:0]      fwd2_data;
	logic                   hazard1;
	logic                   hazard2;
	pipe_pkg::id_ex_t       bundle;

	inst_decoder u_dec (.inst_i(inst_i), .pc_i(pc_i), .rf_rd_o(rf_rd_o), .aluop_o(aluop),
		.wd_o(wd), .wreg_o(wreg), .imm_o(imm), .use_imm_o(use_imm), .link_addr_o(link_addr));

	operand_forward u_fwd1 (.re_i(rf_rd_o.re1), .addr_i(rf_rd_o.addr1), .rf_data_i(rf_data1_i),
		.ex_fwd_i(ex_fwd_i), .mem_fwd_i(mem_fwd_i), .data_o(fwd1_data),
		.load_hazard_o(hazard1));

	operand_forward u_fwd2 (.re_i(rf_rd_o.re2), .addr_i(rf_rd_o.addr2), .rf_data_i(rf_data2_i),
		.ex_fwd_i(ex_fwd_i), .mem_fwd_i(mem_fwd_i), .data_o(fwd2_data),
		.load_hazard_o(hazard2));

	assign stall_o = hazard1 || hazard2;

	// branch compares the raw forwarded registers, not the immediate
	branch_unit u_br (.inst_i(inst_i), .pc_i(pc_i), .op1_i(fwd1_data), .op2_i(fwd2_data),
		.stall_i(stall_o), .branch_o(branch_o));

	assign bundle.aluop     = aluop;
	assign bundle.op1       = (aluop == pipe_pkg::ALU_LUI) ? '0 : fwd1_data;
	assign bundle.op2       = use_imm ? imm : fwd2_data;
	assign bundle.wd        = wd;
	assign bundle.wreg      = wreg;
	assign bundle.link_addr = link_addr;

	id_ex_reg u_id_ex (.clk(clk), .rst_i(rst_i), .stall_i(stall_o), .bundle_i(bundle),
		.id_ex_o(id_ex_o));

endmodule

/* design/inst_decoder.sv */
`timescale 1ns/100ps
`include "id_consts.svh"

module inst_decoder (
	input  isa_pkg::instr_u         inst_i,
	input  logic [`REG_W-1:0]       pc_i,
	output pipe_pkg::rf_read_t      rf_rd_o,
	output pipe_pkg::alu_op_e       aluop_o,
	output logic [`REG_ADDR_W-1:0]  wd_o,
	output logic                    wreg_o,
	output logic [`REG_W-1:0]       imm_o,
	output logic                    use_imm_o,
	output logic [`REG_W-1:0]       link_addr_o
);

	logic [`REG_W-1:0] imm_zext;
	logic [`REG_W-1:0] imm_sext;
	pipe_pkg::alu_op_e r_op;

	assign imm_zext = {{(`REG_W-`IMM_W){1'b0}}, inst_i.i.imm};
	assign imm_sext = {{(`REG_W-`IMM_W){inst_i.i.imm[`IMM_W-1]}}, inst_i.i.imm};

	// return address skips the delay slot
	assign link_addr_o = pc_i + `REG_W'd8;

	// funct to alu op, nop marks an unsupported funct
	always_comb begin
		case (inst_i.r.funct)
			isa_pkg::FN_AND:  r_op = pipe_pkg::ALU_AND;
			isa_pkg::FN_OR:   r_op = pipe_pkg::ALU_OR;
			isa_pkg::FN_XOR:  r_op = pipe_pkg::ALU_XOR;
			isa_pkg::FN_NOR:  r_op = pipe_pkg::ALU_NOR;
			isa_pkg::FN_ADDU: r_op = pipe_pkg::ALU_ADDU;
			isa_pkg::FN_SUBU: r_op = pipe_pkg::ALU_SUBU;
			isa_pkg::FN_SLT:  r_op = pipe_pkg::ALU_SLT;
			default:          r_op = pipe_pkg::ALU_NOP;
		endcase
	end

	always_comb begin
		rf_rd_o   = '0;
		aluop_o   = pipe_pkg::ALU_NOP;
		wd_o      = '0;
		wreg_o    = 1'b0;
		imm_o     = imm_zext;
		use_imm_o = 1'b0;
		case (inst_i.r.opcode)
			isa_pkg::OP_SPECIAL: begin
				if (r_op != pipe_pkg::ALU_NOP) begin
					rf_rd_o.re1   = 1'b1;
					rf_rd_o.re2   = 1'b1;
					rf_rd_o.addr1 = inst_i.r.rs;
					rf_rd_o.addr2 = inst_i.r.rt;
					aluop_o       = r_op;
					wd_o          = inst_i.r.rd;
					wreg_o        = 1'b1;
				end
			end
			isa_pkg::OP_ORI, isa_pkg::OP_ANDI, isa_pkg::OP_XORI: begin
				rf_rd_o.re1   = 1'b1;
				rf_rd_o.addr1 = inst_i.i.rs;
				wd_o          = inst_i.i.rt;
				wreg_o        = 1'b1;
				use_imm_o     = 1'b1;
				case (inst_i.i.opcode)
					isa_pkg::OP_ORI:  aluop_o = pipe_pkg::ALU_OR;
					isa_pkg::OP_ANDI: aluop_o = pipe_pkg::ALU_AND;
					default:          aluop_o = pipe_pkg::ALU_XOR;
				endcase
			end
			isa_pkg::OP_LUI: begin
				// no register read, ex shifts the immediate up
				aluop_o   = pipe_pkg::ALU_LUI;
				wd_o      = inst_i.i.rt;
				wreg_o    = 1'b1;
				use_imm_o = 1'b1;
			end
			isa_pkg::OP_ADDIU, isa_pkg::OP_LW: begin
				rf_rd_o.re1   = 1'b1;
				rf_rd_o.addr1 = inst_i.i.rs;
				wd_o          = inst_i.i.rt;
				wreg_o        = 1'b1;
				imm_o         = imm_sext;
				use_imm_o     = 1'b1;
				if (inst_i.i.opcode == isa_pkg::OP_LW)
					aluop_o = pipe_pkg::ALU_LW;
				else
					aluop_o = pipe_pkg::ALU_ADDU;
			end
			isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
				rf_rd_o.re1   = 1'b1;
				rf_rd_o.re2   = 1'b1;
				rf_rd_o.addr1 = inst_i.i.rs;
				rf_rd_o.addr2 = inst_i.i.rt;
				if (inst_i.i.opcode == isa_pkg::OP_BEQ)
					aluop_o = pipe_pkg::ALU_BEQ;
				else
					aluop_o = pipe_pkg::ALU_BNE;
			end
			isa_pkg::OP_J: begin
				aluop_o = pipe_pkg::ALU_J;
			end
			isa_pkg::OP_JAL: begin
				aluop_o = pipe_pkg::ALU_JAL;
				wd_o    = `LINK_REG;
				wreg_o  = 1'b1;
			end
			default: begin
				// unknown opcode stays a nop
			end
		endcase
	end

endmodule

/* design/isa_pkg.sv */
`include "id_consts.svh"

package isa_pkg;

	// major opcodes kept in this decode stage
	typedef enum logic [`OPCODE_W-1:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23
	} opcode_e;

	// funct field of SPECIAL
	typedef enum logic [`FUNCT_W-1:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a
	} funct_e;

	typedef struct packed {
		opcode_e                opcode;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`REG_ADDR_W-1:0] rd;
		logic [4:0]             shamt;
		funct_e                 funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_e                opcode;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`IMM_W-1:0]      imm;
	} i_fmt_t;

	typedef struct packed {
		opcode_e            opcode;
		logic [`JIDX_W-1:0] index;
	} j_fmt_t;

	// one fetched word, three views of it
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_u;

endpackage

/* design/operand_forward.sv */
`timescale 1ns/100ps
`include "id_consts.svh"

module operand_forward (
	input  logic                   re_i,
	input  logic [`REG_ADDR_W-1:0] addr_i,
	input  logic [`REG_W-1:0]      rf_data_i,
	input  pipe_pkg::fwd_src_t     ex_fwd_i,
	input  pipe_pkg::fwd_src_t     mem_fwd_i,
	output logic [`REG_W-1:0]      data_o,
	output logic                   load_hazard_o
);

	logic live;
	logic ex_hit;
	logic mem_hit;

	// r0 is hardwired, never forwarded
	assign live    = re_i && (addr_i != '0);
	assign ex_hit  = live && ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
	assign mem_hit = live && mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

	// youngest result wins
	assign data_o = ex_hit  ? ex_fwd_i.wdata :
	                mem_hit ? mem_fwd_i.wdata : rf_data_i;

	// load data only exists after mem, so ex cannot supply it
	assign load_hazard_o = live && (ex_fwd_i.aluop == pipe_pkg::ALU_LW) &&
	                       (ex_fwd_i.wd == addr_i);

endmodule

/* design/pipe_pkg.sv */
`include "id_consts.svh"

package pipe_pkg;

	// nop must stay at zero, a bubble is an all zero bundle
	typedef enum logic [4:0] {
		ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR, ALU_ADDU, ALU_SUBU,
		ALU_SLT, ALU_LUI, ALU_LW, ALU_JAL, ALU_BEQ, ALU_BNE, ALU_J
	} alu_op_e;

	typedef struct packed {
		logic                   re1;
		logic                   re2;
		logic [`REG_ADDR_W-1:0] addr1;
		logic [`REG_ADDR_W-1:0] addr2;
	} rf_read_t;

	// result of a later stage, as seen from decode
	typedef struct packed {
		logic                   wreg;
		logic [`REG_ADDR_W-1:0] wd;
		logic [`REG_W-1:0]      wdata;
		alu_op_e                aluop;
	} fwd_src_t;

	typedef struct packed {
		alu_op_e                aluop;
		logic [`REG_W-1:0]      op1;
		logic [`REG_W-1:0]      op2;
		logic [`REG_ADDR_W-1:0] wd;
		logic                   wreg;
		logic [`REG_W-1:0]      link_addr;
	} id_ex_t;

	typedef struct packed {
		logic              taken;
		logic [`REG_W-1:0] target;
	} branch_t;

endpackage

/* filelist.f */
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/inst_decoder.sv
design/operand_forward.sv
design/branch_unit.sv
design/id_ex_reg.sv
design/id_stage.sv
verif/tb_clock.sv
verif/id_stage_asserts.sv
verif/id_stage_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module id_stage_tb -f filelist.f -o id_stage_sim
./obj_dir/id_stage_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
	exit 1
fi
grep -q "all tests passed" sim.log

/* verif/id_stage_asserts.sv */
`timescale 1ns/100ps
`include "id_consts.svh"

module id_stage_asserts (
	input logic               clk,
	input logic               rst_i,
	input logic [`REG_W-1:0]  pc_i,
	input isa_pkg::instr_u    inst_i,
	input pipe_pkg::fwd_src_t ex_fwd_i,
	input pipe_pkg::fwd_src_t mem_fwd_i,
	input logic [`REG_W-1:0]  rf_data1_i,
	input logic [`REG_W-1:0]  rf_data2_i,
	input pipe_pkg::rf_read_t rf_rd_o,
	input pipe_pkg::branch_t  branch_o,
	input logic               stall_o,
	input pipe_pkg::id_ex_t   id_ex_o
);

	int unsigned fails = 0;
	pipe_pkg::id_ex_t exp_d;
	pipe_pkg::id_ex_t exp_q;
	pipe_pkg::rf_read_t exp_rd;
	logic [`REG_W-1:0] sext;
	logic [`REG_W-1:0] pc4;
	logic run;
	logic hazard;
	logic br_eq;
	logic exp_taken;

	// ex result wins over mem, r0 always reads the file
	function automatic logic [`REG_W-1:0] fwd_value(input logic [`REG_ADDR_W-1:0] a,
		input logic [`REG_W-1:0] rf, input pipe_pkg::fwd_src_t ex, input pipe_pkg::fwd_src_t mem);
		if (a == '0)
			return rf;
		if (ex.wreg && ex.wd == a)
			return ex.wdata;
		if (mem.wreg && mem.wd == a)
			return mem.wdata;
		return rf;
	endfunction

	function automatic pipe_pkg::alu_op_e r_aluop(input logic [`FUNCT_W-1:0] fn);
		case (fn)
			isa_pkg::FN_AND:  return pipe_pkg::ALU_AND;
			isa_pkg::FN_OR:   return pipe_pkg::ALU_OR;
			isa_pkg::FN_XOR:  return pipe_pkg::ALU_XOR;
			isa_pkg::FN_NOR:  return pipe_pkg::ALU_NOR;
			isa_pkg::FN_ADDU: return pipe_pkg::ALU_ADDU;
			isa_pkg::FN_SUBU: return pipe_pkg::ALU_SUBU;
			isa_pkg::FN_SLT:  return pipe_pkg::ALU_SLT;
			default:          return pipe_pkg::ALU_NOP;
		endcase
	endfunction

	// registers each instruction reads
	always_comb begin
		exp_rd = '0;
		if ((inst_i.r.opcode == isa_pkg::OP_SPECIAL &&
				r_aluop(inst_i.r.funct) != pipe_pkg::ALU_NOP) ||
				inst_i.i.opcode inside {isa_pkg::OP_BEQ, isa_pkg::OP_BNE}) begin
			exp_rd.re2   = 1'b1;
			exp_rd.addr2 = inst_i.r.rt;
		end
		if (exp_rd.re2 || inst_i.i.opcode inside {isa_pkg::OP_ORI, isa_pkg::OP_ANDI,
				isa_pkg::OP_XORI, isa_pkg::OP_ADDIU, isa_pkg::OP_LW}) begin
			exp_rd.re1   = 1'b1;
			exp_rd.addr1 = inst_i.r.rs;
		end
	end

	// load in ex targets a nonzero register being read
	assign hazard = ex_fwd_i.aluop == pipe_pkg::ALU_LW &&
		((exp_rd.re1 && exp_rd.addr1 != '0 && ex_fwd_i.wd == exp_rd.addr1) ||
		(exp_rd.re2 && exp_rd.addr2 != '0 && ex_fwd_i.wd == exp_rd.addr2));

	assign run  = !rst_i && !hazard;
	assign sext = {{(`REG_W-`IMM_W){inst_i.i.imm[`IMM_W-1]}}, inst_i.i.imm};
	assign pc4  = pc_i + 32'd4;
	assign br_eq = fwd_value(inst_i.i.rs, rf_data1_i, ex_fwd_i, mem_fwd_i) ==
	               fwd_value(inst_i.i.rt, rf_data2_i, ex_fwd_i, mem_fwd_i);

	always_comb begin
		exp_taken = 1'b0;
		case (inst_i.j.opcode)
			isa_pkg::OP_J, isa_pkg::OP_JAL: exp_taken = 1'b1;
			isa_pkg::OP_BEQ: exp_taken = br_eq;
			isa_pkg::OP_BNE: exp_taken = !br_eq;
			default:         exp_taken = 1'b0;
		endcase
		if (hazard)
			exp_taken = 1'b0;
	end

	// expected bundle fields, one edge ahead of id_ex_o
	always_comb begin
		exp_d           = '0;
		exp_d.op1       = fwd_value(inst_i.i.rs, rf_data1_i, ex_fwd_i, mem_fwd_i);
		exp_d.link_addr = pc_i + 32'd8;
		exp_d.aluop     = r_aluop(inst_i.r.funct);
		exp_d.wd        = inst_i.i.rt;
		exp_d.op2       = {{(`REG_W-`IMM_W){1'b0}}, inst_i.i.imm};
		if (inst_i.i.opcode == isa_pkg::OP_SPECIAL)
			exp_d.wd = inst_i.r.rd;
		else if (inst_i.i.opcode == isa_pkg::OP_JAL)
			exp_d.wd = 5'd31;
		else if (inst_i.i.opcode inside {isa_pkg::OP_ADDIU, isa_pkg::OP_LW})
			exp_d.op2 = sext;
		if (inst_i.i.opcode == isa_pkg::OP_LUI)
			exp_d.op1 = '0;
	end

	always_ff @(posedge clk) begin
		exp_q <= exp_d;
	end

	a_reset: assert property (@(posedge clk) rst_i |=>
		(!id_ex_o.wreg && id_ex_o.aluop == pipe_pkg::ALU_NOP))
		else begin fails++; $error("error %0t id_ex_o.aluop got %0d exp 0 wreg got %b exp 0",
			$time, id_ex_o.aluop, id_ex_o.wreg); end

	a_rf_rd: assert property (@(posedge clk) rf_rd_o == exp_rd)
		else begin fails++; $error("error %0t rf_rd_o got %h exp %h", $time,
			rf_rd_o, exp_rd); end

	a_imm: assert property (@(posedge clk) run && inst_i.i.opcode inside {isa_pkg::OP_ORI,
		isa_pkg::OP_ANDI, isa_pkg::OP_XORI, isa_pkg::OP_LUI, isa_pkg::OP_ADDIU, isa_pkg::OP_LW}
		|=> (id_ex_o.op2 == exp_q.op2 && id_ex_o.wd == exp_q.wd))
		else begin fails++; $error("error %0t id_ex_o.op2 got %h exp %h wd got %0d exp %0d",
			$time, id_ex_o.op2, exp_q.op2, id_ex_o.wd, exp_q.wd); end

	a_fwd: assert property (@(posedge clk) run &&
		(exp_rd.re1 || inst_i.i.opcode == isa_pkg::OP_LUI) |=> id_ex_o.op1 == exp_q.op1)
		else begin fails++; $error("error %0t id_ex_o.op1 got %h exp %h", $time,
			id_ex_o.op1, exp_q.op1); end

	a_load_use: assert property (@(posedge clk) stall_o == hazard)
		else begin fails++; $error("error %0t stall_o got %b exp %b", $time,
			stall_o, hazard); end

	a_bubble: assert property (@(posedge clk) hazard |=> id_ex_o == '0)
		else begin fails++; $error("error %0t id_ex_o got %h exp 0", $time, id_ex_o); end

	a_taken: assert property (@(posedge clk) branch_o.taken == exp_taken)
		else begin fails++; $error("error %0t branch_o.taken got %b exp %b", $time,
			branch_o.taken, exp_taken); end

	a_cond: assert property (@(posedge clk) inst_i.i.opcode inside {isa_pkg::OP_BEQ,
		isa_pkg::OP_BNE} |-> branch_o.target == pc4 + (sext << 2))
		else begin fails++; $error("error %0t branch_o.target got %h exp %h", $time,
			branch_o.target, pc4 + (sext << 2)); end

	a_jump: assert property (@(posedge clk) inst_i.j.opcode inside {isa_pkg::OP_J,
		isa_pkg::OP_JAL} |-> branch_o.target == {pc4[31:28], inst_i.j.index, 2'b00})
		else begin fails++; $error("error %0t branch_o.target got %h exp %h", $time,
			branch_o.target, {pc4[31:28], inst_i.j.index, 2'b00}); end

	a_jal: assert property (@(posedge clk) run && inst_i.j.opcode == isa_pkg::OP_JAL |=>
		id_ex_o.wd == 5'd31 && id_ex_o.wreg && id_ex_o.link_addr == exp_q.link_addr)
		else begin fails++; $error("error %0t id_ex_o wd %0d wreg %b link_addr %h exp 31 1 %h",
			$time, id_ex_o.wd, id_ex_o.wreg, id_ex_o.link_addr, exp_q.link_addr); end

	a_rtype: assert property (@(posedge clk) run && inst_i.r.opcode == isa_pkg::OP_SPECIAL &&
		r_aluop(inst_i.r.funct) != pipe_pkg::ALU_NOP |=> id_ex_o.wreg &&
		id_ex_o.wd == exp_q.wd && id_ex_o.aluop == exp_q.aluop)
		else begin fails++; $error("error %0t id_ex_o aluop %0d wd %0d wreg %b exp %0d %0d 1",
			$time, id_ex_o.aluop, id_ex_o.wd, id_ex_o.wreg, exp_q.aluop, exp_q.wd); end

endmodule

bind id_stage id_stage_asserts u_asserts (.*);

/* verif/id_stage_tb.sv */
`timescale 1ns/100ps
`include "id_consts.svh"

module id_stage_tb;

	localparam int NUM_STEPS = 24;

	logic clk;
	logic rst_i;
	logic [`REG_W-1:0] pc_i;
	isa_pkg::instr_u inst_i;
	pipe_pkg::fwd_src_t ex_fwd_i;
	pipe_pkg::fwd_src_t mem_fwd_i;
	logic [`REG_W-1:0] rf_data1_i;
	logic [`REG_W-1:0] rf_data2_i;
	pipe_pkg::rf_read_t rf_rd_o;
	pipe_pkg::branch_t branch_o;
	logic stall_o;
	pipe_pkg::id_ex_t id_ex_o;
	logic [31:0] lfsr = 32'h9e76_3f03;

	tb_clock u_clk (.clk_o(clk), .rst_o(rst_i));

	id_stage u_dut (.clk(clk), .rst_i(rst_i), .pc_i(pc_i), .inst_i(inst_i),
		.ex_fwd_i(ex_fwd_i), .mem_fwd_i(mem_fwd_i), .rf_data1_i(rf_data1_i),
		.rf_data2_i(rf_data2_i), .rf_rd_o(rf_rd_o), .branch_o(branch_o),
		.stall_o(stall_o), .id_ex_o(id_ex_o));

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [31:0] enc_i(input isa_pkg::opcode_e op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input isa_pkg::funct_e fn);
		return {isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	// ex mode 0 idle, 1 alu write to rs, 2 load to rs, 3 rs write equal to rf_data2,
	// 4 load to rt
	task automatic run_step(input logic [31:0] word, input int ex_mode, input int mem_mode);
		@(negedge clk);
		if (!stall_o)
			pc_i = pc_i + 32'd4;
		inst_i = word;
		rf_data1_i = take_bits(32);
		rf_data2_i = take_bits(32);
		ex_fwd_i = '0;
		mem_fwd_i = '0;
		if (ex_mode != 0) begin
			ex_fwd_i.wreg = 1'b1;
			ex_fwd_i.wd = (ex_mode == 4) ? word[20:16] : word[25:21];
			ex_fwd_i.wdata = (ex_mode == 3) ? rf_data2_i : take_bits(32);
			ex_fwd_i.aluop = (ex_mode == 2 || ex_mode == 4) ? pipe_pkg::ALU_LW :
				pipe_pkg::ALU_ADDU;
		end
		if (mem_mode != 0) begin
			mem_fwd_i.wreg = 1'b1;
			mem_fwd_i.wd = word[25:21];
			mem_fwd_i.wdata = take_bits(32);
			mem_fwd_i.aluop = pipe_pkg::ALU_ADDU;
		end
	endtask

	initial begin
		pc_i = '0;
		inst_i = '0;
		ex_fwd_i = '0;
		mem_fwd_i = '0;
		rf_data1_i = '0;
		rf_data2_i = '0;
		wait (!rst_i);
		pc_i = take_bits(30) << 2;
		run_step(enc_i(isa_pkg::OP_ORI, 5'd3, 5'd4, 16'h8001), 0, 0);
		run_step(enc_i(isa_pkg::OP_ANDI, 5'd5, 5'd6, 16'h00ff), 0, 0);
		run_step(enc_i(isa_pkg::OP_XORI, 5'd7, 5'd8, 16'hf0f0), 0, 0);
		run_step(enc_i(isa_pkg::OP_LUI, 5'd0, 5'd9, 16'hbeef), 0, 0);
		run_step(enc_i(isa_pkg::OP_ADDIU, 5'd10, 5'd11, 16'h8004), 0, 0);
		run_step(enc_i(isa_pkg::OP_LW, 5'd12, 5'd13, 16'h0010), 0, 0);
		run_step(enc_r(5'd1, 5'd2, 5'd5, isa_pkg::FN_ADDU), 1, 0);
		run_step(enc_r(5'd3, 5'd4, 5'd6, isa_pkg::FN_SUBU), 1, 1);
		run_step(enc_r(5'd4, 5'd5, 5'd7, isa_pkg::FN_AND), 0, 1);
		run_step(enc_r(5'd0, 5'd6, 5'd8, isa_pkg::FN_OR), 1, 1);
		run_step(enc_r(5'd7, 5'd8, 5'd9, isa_pkg::FN_XOR), 0, 0);
		run_step(enc_r(5'd9, 5'd10, 5'd11, isa_pkg::FN_NOR), 0, 0);
		run_step(enc_r(5'd11, 5'd12, 5'd13, isa_pkg::FN_SLT), 0, 0);
		// load-use stall, then the same instruction again
		run_step(enc_i(isa_pkg::OP_ORI, 5'd14, 5'd15, 16'h0001), 2, 0);
		run_step(enc_i(isa_pkg::OP_ORI, 5'd14, 5'd15, 16'h0001), 0, 0);
		run_step(enc_i(isa_pkg::OP_BEQ, 5'd16, 5'd17, 16'hfffc), 3, 0);
		run_step(enc_i(isa_pkg::OP_BNE, 5'd18, 5'd19, 16'h0020), 0, 0);
		run_step(enc_i(isa_pkg::OP_BEQ, 5'd20, 5'd21, 16'h0008), 2, 0);
		run_step(enc_i(isa_pkg::OP_BEQ, 5'd20, 5'd21, 16'h0008), 0, 0);
		// load into rt holds back a branch that would be taken
		run_step(enc_i(isa_pkg::OP_BNE, 5'd22, 5'd23, 16'h0040), 4, 0);
		run_step(enc_i(isa_pkg::OP_BNE, 5'd22, 5'd23, 16'h0040), 0, 0);
		run_step({isa_pkg::OP_J, 26'h2abcdef}, 0, 0);
		run_step({isa_pkg::OP_JAL, 26'h0123456}, 0, 0);
		run_step(32'hfc00_0000, 0, 0);
		repeat (2) @(negedge clk);
		if (u_dut.u_asserts.fails == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("tests failed");
			$fatal(1, "an assertion on id_stage failed");
		end
	end

	always @(negedge clk) begin
		if (u_dut.u_asserts.fails != 0) begin
			$display("tests failed");
			$fatal(1, "an assertion on id_stage failed");
		end
	end

	// reset, all steps and a margin of ten cycles
	initial begin
		#((NUM_STEPS + 12) * 100);
		$display("tests failed");
		$fatal(1, "watchdog expired before the directed steps finished");
	end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		rst_o = 1'b1;
		// two rising edges in reset
		repeat (2) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

	always #50 clk_o = ~clk_o;

endmodule
